// File: Bender.yml
package:
  name: colmix

sources:
  - hw/colmix_pkg.sv
  - hw/colmix_regs.sv
  - hw/layer_select.sv
  - hw/prio_resolver.sv
  - hw/palette_ram.sv
  - hw/colmix_top.sv
  - target: test
    files:
      - verif/colmix_tb.sv

// File: flist.f
hw/colmix_pkg.sv
hw/colmix_regs.sv
hw/layer_select.sv
hw/prio_resolver.sv
hw/palette_ram.sv
hw/colmix_top.sv
verif/colmix_tb.sv

// File: hw/colmix_pkg.sv
package colmix_pkg;

    // Pixel field widths
    typedef logic [3:0]  color_t;
    typedef logic [4:0]  pal_t;
    typedef logic [2:0]  layer_code_t;
    typedef logic [1:0]  prio_grp_t;
    typedef logic [11:0] pxl_t;
    typedef logic [15:0] pal_word_t;

    // Raw layer inputs
    typedef logic [8:0]  obj_pxl_t;
    typedef logic [10:0] scr_pxl_t;

    // APB byte address
    typedef logic [13:0] apb_addr_t;

    // Source layer codes, top bits of the palette index
    localparam layer_code_t LYR_OBJ  = 3'd0;
    localparam layer_code_t LYR_SCR1 = 3'd1;
    localparam layer_code_t LYR_SCR2 = 3'd2;
    localparam layer_code_t LYR_SCR3 = 3'd3;
    localparam layer_code_t LYR_STAR = 3'd4;

    // Pen 15 never shows
    localparam color_t COLOR_TRANSP = 4'hf;

    localparam int NUM_LAYERS = 6;
    localparam int PAL_DEPTH  = 4096;

    typedef struct packed {
        prio_grp_t   group;
        layer_code_t code;
        pal_t        pal;
        color_t      color;
    } layer_entry_t;

    // Filler behind the last real layer, always transparent
    localparam layer_entry_t BLANK_ENTRY = '{group: 2'd3, code: 3'd5, pal: 5'd31, color: 4'hf};

    typedef struct packed {
        logic [15:0]      layer_ctrl;
        logic [4:0][7:0]  layer_mask;
        logic [3:0][15:0] prio;
        logic [3:0]       gfx_en;
    } mix_cfg_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        apb_addr_t   paddr;
        logic [15:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [15:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Palette port seen from the register block
    typedef struct packed {
        logic      we;
        logic      re;
        pxl_t      addr;
        pal_word_t wdata;
    } pal_bus_t;

    // Register map, byte addresses
    localparam apb_addr_t ADDR_LAYER_CTRL = 14'h000;
    localparam apb_addr_t ADDR_MASK0      = 14'h002;
    localparam apb_addr_t ADDR_MASK1      = 14'h004;
    localparam apb_addr_t ADDR_MASK2      = 14'h006;
    localparam apb_addr_t ADDR_MASK3      = 14'h008;
    localparam apb_addr_t ADDR_MASK4      = 14'h00a;
    localparam apb_addr_t ADDR_PRIO0      = 14'h00c;
    localparam apb_addr_t ADDR_PRIO1      = 14'h00e;
    localparam apb_addr_t ADDR_PRIO2      = 14'h010;
    localparam apb_addr_t ADDR_PRIO3      = 14'h012;
    localparam apb_addr_t ADDR_GFX_EN     = 14'h014;
    localparam apb_addr_t PAL_BASE        = 14'h2000;

endpackage

// File: hw/colmix_regs.sv
`timescale 1ns/1ps

module colmix_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  colmix_pkg::apb_req_t  apb_req,
    output colmix_pkg::apb_rsp_t  apb_rsp,
    output colmix_pkg::mix_cfg_t  cfg,
    output colmix_pkg::pal_bus_t  pal_bus,
    input  colmix_pkg::pal_word_t pal_rdata
);
    import colmix_pkg::*;

    logic        setup;
    logic        access;
    logic        pal_sel;
    logic        reg_hit;
    logic [15:0] reg_rdata;
    logic        pready_q;
    logic        pslverr_q;

    // APB phases
    assign setup   = apb_req.psel & ~apb_req.penable;
    assign access  = apb_req.psel & apb_req.penable;
    // Upper half of the map is palette
    assign pal_sel = (apb_req.paddr >= PAL_BASE);

    // Register decode and readback
    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = 16'h0000;
        case (apb_req.paddr)
            ADDR_LAYER_CTRL: reg_rdata = cfg.layer_ctrl;
            ADDR_MASK0:      reg_rdata = {8'h00, cfg.layer_mask[0]};
            ADDR_MASK1:      reg_rdata = {8'h00, cfg.layer_mask[1]};
            ADDR_MASK2:      reg_rdata = {8'h00, cfg.layer_mask[2]};
            ADDR_MASK3:      reg_rdata = {8'h00, cfg.layer_mask[3]};
            ADDR_MASK4:      reg_rdata = {8'h00, cfg.layer_mask[4]};
            ADDR_PRIO0:      reg_rdata = cfg.prio[0];
            ADDR_PRIO1:      reg_rdata = cfg.prio[1];
            ADDR_PRIO2:      reg_rdata = cfg.prio[2];
            ADDR_PRIO3:      reg_rdata = cfg.prio[3];
            ADDR_GFX_EN:     reg_rdata = {12'h000, cfg.gfx_en};
            default:         reg_hit   = 1'b0;
        endcase
    end

    // Handshake
    // Everything but a palette read is ready in the first access cycle,
    // so pready is set up at the end of setup
    always_ff @(posedge clk) begin
        if (reset) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
            if (setup) begin
                pready_q  <= ~(pal_sel & ~apb_req.pwrite);
                pslverr_q <= ~pal_sel & ~reg_hit;
            end else if (access & pal_sel & ~apb_req.pwrite & ~pready_q) begin
                // Palette word lands next cycle
                pready_q <= 1'b1;
            end
        end
    end

    // Configuration writes on the completing edge
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (access & apb_req.pwrite & pready_q) begin
            case (apb_req.paddr)
                ADDR_LAYER_CTRL: cfg.layer_ctrl    <= apb_req.pwdata;
                ADDR_MASK0:      cfg.layer_mask[0] <= apb_req.pwdata[7:0];
                ADDR_MASK1:      cfg.layer_mask[1] <= apb_req.pwdata[7:0];
                ADDR_MASK2:      cfg.layer_mask[2] <= apb_req.pwdata[7:0];
                ADDR_MASK3:      cfg.layer_mask[3] <= apb_req.pwdata[7:0];
                ADDR_MASK4:      cfg.layer_mask[4] <= apb_req.pwdata[7:0];
                ADDR_PRIO0:      cfg.prio[0]       <= apb_req.pwdata;
                ADDR_PRIO1:      cfg.prio[1]       <= apb_req.pwdata;
                ADDR_PRIO2:      cfg.prio[2]       <= apb_req.pwdata;
                ADDR_PRIO3:      cfg.prio[3]       <= apb_req.pwdata;
                ADDR_GFX_EN:     cfg.gfx_en        <= apb_req.pwdata[3:0];
                default:         ;
            endcase
        end
    end

    // Palette strobes, one cycle each
    always_comb begin
        pal_bus.we    = access & apb_req.pwrite & pal_sel;
        pal_bus.re    = access & ~apb_req.pwrite & pal_sel & ~pready_q;
        // Word index, byte bit dropped
        pal_bus.addr  = apb_req.paddr[12:1];
        pal_bus.wdata = apb_req.pwdata;
    end

    // Unmapped reads fall out as zero from the decode
    assign apb_rsp.prdata  = pal_sel ? pal_rdata : reg_rdata;
    assign apb_rsp.pready  = pready_q;
    assign apb_rsp.pslverr = pslverr_q;

endmodule

// File: hw/colmix_top.sv
`timescale 1ns/1ps

module colmix_top (
    input  logic                  clk,
    input  logic                  reset,
    input  colmix_pkg::apb_req_t  apb_req,
    output colmix_pkg::apb_rsp_t  apb_rsp,
    input  logic                  pxl_cen,
    input  colmix_pkg::obj_pxl_t  obj_pxl,
    input  colmix_pkg::scr_pxl_t  scr1_pxl,
    input  colmix_pkg::scr_pxl_t  scr2_pxl,
    input  colmix_pkg::scr_pxl_t  scr3_pxl,
    input  colmix_pkg::obj_pxl_t  star0_pxl,
    input  colmix_pkg::obj_pxl_t  star1_pxl,
    output colmix_pkg::pxl_t      pxl,
    output colmix_pkg::pal_word_t rgb
);
    import colmix_pkg::*;

    mix_cfg_t     cfg;
    pal_bus_t     pal_bus;
    pal_word_t    pal_rdata;
    layer_entry_t layers [NUM_LAYERS];

    // CPU registers and palette window
    colmix_regs u_colmix_regs (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cfg       (cfg),
        .pal_bus   (pal_bus),
        .pal_rdata (pal_rdata)
    );

    // Masking and ordering
    layer_select u_layer_select (
        .clk       (clk),
        .reset     (reset),
        .pxl_cen   (pxl_cen),
        .cfg       (cfg),
        .obj_pxl   (obj_pxl),
        .scr1_pxl  (scr1_pxl),
        .scr2_pxl  (scr2_pxl),
        .scr3_pxl  (scr3_pxl),
        .star0_pxl (star0_pxl),
        .star1_pxl (star1_pxl),
        .layers    (layers)
    );

    // Serial priority walk
    prio_resolver u_prio_resolver (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .cfg     (cfg),
        .layers  (layers),
        .pxl     (pxl)
    );

    palette_ram u_palette_ram (
        .clk       (clk),
        .reset     (reset),
        .pxl       (pxl),
        .rgb       (rgb),
        .pal_bus   (pal_bus),
        .pal_rdata (pal_rdata)
    );

endmodule

// File: hw/layer_select.sv
`timescale 1ns/1ps

module layer_select (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pxl_cen,
    input  colmix_pkg::mix_cfg_t     cfg,
    input  colmix_pkg::obj_pxl_t     obj_pxl,
    input  colmix_pkg::scr_pxl_t     scr1_pxl,
    input  colmix_pkg::scr_pxl_t     scr2_pxl,
    input  colmix_pkg::scr_pxl_t     scr3_pxl,
    input  colmix_pkg::obj_pxl_t     star0_pxl,
    input  colmix_pkg::obj_pxl_t     star1_pxl,
    output colmix_pkg::layer_entry_t layers [colmix_pkg::NUM_LAYERS]
);
    import colmix_pkg::*;

    logic [4:0]   lyren;
    layer_entry_t obj_e;
    layer_entry_t scr1_e;
    layer_entry_t scr2_e;
    layer_entry_t scr3_e;
    layer_entry_t star0_e;
    layer_entry_t star1_e;

    // Disabled layer shows nothing
    function automatic color_t mask_pen(input color_t pen, input logic en);
        return en ? pen : COLOR_TRANSP;
    endfunction

    // Order slot select: 0 sprite, 1..3 scroll
    function automatic layer_entry_t pick(input logic [1:0] sel);
        case (sel)
            2'd0:    return obj_e;
            2'd1:    return scr1_e;
            2'd2:    return scr2_e;
            default: return scr3_e;
        endcase
    endfunction

    // Layer i live when its mask hits an enabled ctrl bit
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            lyren[i] = |(cfg.layer_mask[i][5:0] & cfg.layer_ctrl[5:0]);
        end
    end

    // Sprite gated by gfx_en only
    assign obj_e = '{group: 2'd0, code: LYR_OBJ, pal: obj_pxl[8:4],
                     color: mask_pen(obj_pxl[3:0], cfg.gfx_en[3])};

    // Scroll pixels carry their group in the top bits
    assign scr1_e = '{group: scr1_pxl[10:9], code: LYR_SCR1, pal: scr1_pxl[8:4],
                      color: mask_pen(scr1_pxl[3:0], lyren[0] & cfg.gfx_en[0])};
    assign scr2_e = '{group: scr2_pxl[10:9], code: LYR_SCR2, pal: scr2_pxl[8:4],
                      color: mask_pen(scr2_pxl[3:0], lyren[1] & cfg.gfx_en[1])};
    assign scr3_e = '{group: scr3_pxl[10:9], code: LYR_SCR3, pal: scr3_pxl[8:4],
                      color: mask_pen(scr3_pxl[3:0], lyren[2] & cfg.gfx_en[2])};

    // Stars use masks 3 and 4
    assign star0_e = '{group: 2'd0, code: LYR_STAR, pal: star0_pxl[8:4],
                       color: mask_pen(star0_pxl[3:0], lyren[3])};
    assign star1_e = '{group: 2'd0, code: LYR_STAR, pal: star1_pxl[8:4],
                       color: mask_pen(star1_pxl[3:0], lyren[4])};

    // Index 0 is the back layer, 5 the front
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_LAYERS; i++) begin
                layers[i] <= BLANK_ENTRY;
            end
        end else if (pxl_cen) begin
            layers[0] <= star1_e;
            layers[1] <= star0_e;
            layers[2] <= pick(cfg.layer_ctrl[7:6]);
            layers[3] <= pick(cfg.layer_ctrl[9:8]);
            layers[4] <= pick(cfg.layer_ctrl[11:10]);
            layers[5] <= pick(cfg.layer_ctrl[13:12]);
        end
    end

endmodule

// File: hw/palette_ram.sv
`timescale 1ns/1ps

module palette_ram (
    input  logic                  clk,
    input  logic                  reset,
    input  colmix_pkg::pxl_t      pxl,
    output colmix_pkg::pal_word_t rgb,
    input  colmix_pkg::pal_bus_t  pal_bus,
    output colmix_pkg::pal_word_t pal_rdata
);
    import colmix_pkg::*;

    pal_word_t mem [PAL_DEPTH];

    // Pixel side, read every clock
    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= '0;
        end else begin
            rgb <= mem[pxl];
        end
    end

    // CPU side write and strobed read
    always_ff @(posedge clk) begin
        if (pal_bus.we) begin
            mem[pal_bus.addr] <= pal_bus.wdata;
        end
        if (pal_bus.re) begin
            pal_rdata <= mem[pal_bus.addr];
        end
    end

endmodule

// File: hw/prio_resolver.sv
`timescale 1ns/1ps

module prio_resolver (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pxl_cen,
    input  colmix_pkg::mix_cfg_t     cfg,
    input  colmix_pkg::layer_entry_t layers [colmix_pkg::NUM_LAYERS],
    output colmix_pkg::pxl_t         pxl
);
    import colmix_pkg::*;

    localparam int QLEN = NUM_LAYERS - 1;

    layer_entry_t cur;
    layer_entry_t queue [QLEN];
    logic         check_prio;
    logic         has_prio;
    logic         head_obj;
    logic         take;

    // Pen mask of the current pixel's group
    assign has_prio = cfg.prio[cur.group][cur.color];
    assign head_obj = (queue[0].code == LYR_OBJ);

    // Head wins over a transparent pixel, or when opaque and not a
    // sprite blocked by the current group's mask
    assign take = (cur.color == COLOR_TRANSP) ||
                  ((queue[0].color != COLOR_TRANSP) && !(head_obj && check_prio && has_prio));

    always_ff @(posedge clk) begin
        if (reset) begin
            pxl        <= '0;
            cur        <= BLANK_ENTRY;
            check_prio <= 1'b0;
            for (int i = 0; i < QLEN; i++) begin
                queue[i] <= BLANK_ENTRY;
            end
        end else if (pxl_cen) begin
            // Publish last walk and start the next from the back layer
            pxl        <= {cur.code, cur.pal, cur.color};
            cur        <= layers[0];
            check_prio <= 1'b0;
            for (int i = 0; i < QLEN; i++) begin
                queue[i] <= layers[i + 1];
            end
        end else begin
            if (take) begin
                cur        <= queue[0];
                // Stars never arm the sprite check
                check_prio <= (queue[0].code != LYR_STAR);
            end else begin
                check_prio <= 1'b0;
            end
            // Advance toward the front, blank fills in behind
            for (int i = 0; i < QLEN - 1; i++) begin
                queue[i] <= queue[i + 1];
            end
            queue[QLEN-1] <= BLANK_ENTRY;
        end
    end

endmodule

// File: verif/colmix_tb.sv
`timescale 1ns/1ps

module colmix_tb;
    import colmix_pkg::*;

    localparam int APB_TIMEOUT = 20;

    // Expected pixel, flagged when it should be compared
    typedef struct packed {
        logic chk;
        pxl_t value;
    } exp_pxl_t;

    logic      clk = 1'b0;
    logic      reset;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    logic      pxl_cen;
    obj_pxl_t  obj_pxl, star0_pxl, star1_pxl;
    scr_pxl_t  scr1_pxl, scr2_pxl, scr3_pxl;
    pxl_t      pxl;
    pal_word_t rgb;

    // Model state
    mix_cfg_t    cfg_model;
    pal_word_t   pal_copy [PAL_DEPTH];
    exp_pxl_t    exp_q [$];
    logic [31:0] rng_state = 32'h4de3;
    apb_addr_t   holes [3] = '{14'h016, 14'h0ff0, 14'h1ffe};
    int          error_count = 0;
    int          check_count = 0;
    int          cen_count = 0;
    logic        cen_edge;
    logic        rgb_due;
    pxl_t        rgb_idx;
    pxl_t        last_pxl;

    colmix_top u_colmix_top (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pxl_cen   (pxl_cen),
        .obj_pxl   (obj_pxl),
        .scr1_pxl  (scr1_pxl),
        .scr2_pxl  (scr2_pxl),
        .scr3_pxl  (scr3_pxl),
        .star0_pxl (star0_pxl),
        .star1_pxl (star1_pxl),
        .pxl       (pxl),
        .rgb       (rgb)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // 32-bit xorshift
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("[ERROR] %s expected 0x%04h got 0x%04h", name, exp, act);
        end
    endtask

    // Register index is the word address, 0 to 10
    function automatic logic [15:0] model_reg(input int k);
        case (k)
            0:             return cfg_model.layer_ctrl;
            1, 2, 3, 4, 5: return {8'h00, cfg_model.layer_mask[k-1]};
            6, 7, 8, 9:    return cfg_model.prio[k-6];
            default:       return {12'h000, cfg_model.gfx_en};
        endcase
    endfunction

    // Walk back to front by the priority rule
    function automatic pxl_t model_pxl(input obj_pxl_t obj, input scr_pxl_t s1,
                                       input scr_pxl_t s2, input scr_pxl_t s3,
                                       input obj_pxl_t st0, input obj_pxl_t st1);
        logic [4:0]   en;
        layer_entry_t src [4];
        layer_entry_t ord [7];
        layer_entry_t cur;
        logic         chk;
        logic         blocked;
        for (int i = 0; i < 5; i++) begin
            en[i] = |(cfg_model.layer_mask[i][5:0] & cfg_model.layer_ctrl[5:0]);
        end
        src[0] = {2'd0, LYR_OBJ, obj[8:4], (cfg_model.gfx_en[3] ? obj[3:0] : 4'hf)};
        src[1] = {s1[10:9], LYR_SCR1, s1[8:4], ((en[0] & cfg_model.gfx_en[0]) ? s1[3:0] : 4'hf)};
        src[2] = {s2[10:9], LYR_SCR2, s2[8:4], ((en[1] & cfg_model.gfx_en[1]) ? s2[3:0] : 4'hf)};
        src[3] = {s3[10:9], LYR_SCR3, s3[8:4], ((en[2] & cfg_model.gfx_en[2]) ? s3[3:0] : 4'hf)};
        // Star 1 at the very back
        ord[0] = {2'd0, LYR_STAR, st1[8:4], (en[4] ? st1[3:0] : 4'hf)};
        ord[1] = {2'd0, LYR_STAR, st0[8:4], (en[3] ? st0[3:0] : 4'hf)};
        for (int k = 0; k < 4; k++) begin
            ord[k+2] = src[cfg_model.layer_ctrl[6+2*k +: 2]];
        end
        // Seven clocks per pixel leave one step against a blank
        ord[6] = BLANK_ENTRY;
        cur = ord[0];
        chk = 1'b0;
        for (int i = 1; i < 7; i++) begin
            blocked = (ord[i].code == LYR_OBJ) && chk && cfg_model.prio[cur.group][cur.color];
            if (cur.color == 4'hf || (ord[i].color != 4'hf && !blocked)) begin
                cur = ord[i];
                chk = (ord[i].code != LYR_STAR);
            end else begin
                chk = 1'b0;
            end
        end
        return {cur.code, cur.pal, cur.color};
    endfunction

    // One APB transfer, setup then access until pready
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err);
        int n;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!apb_rsp.pready && n < APB_TIMEOUT);
        if (!apb_rsp.pready) begin
            $display("APB transfer to address 0x%04h never completed", addr);
            $display("checks %0d, errors %0d", check_count, error_count);
            $display("=== FAIL ===");
            $finish;
        end else begin
            // Palette reads wait one extra cycle for the RAM word
            check_value("pready", (!write && addr >= PAL_BASE) ? 16'd2 : 16'd1, n[15:0]);
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            apb_req <= '0;
        end
    endtask

    // Register write, model copy follows
    task automatic write_cfg(input apb_addr_t addr, input logic [15:0] data);
        logic [15:0] rd;
        logic        err;
        int          k;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value("pslverr", 16'h0000, {15'h0, err});
        k = addr >> 1;
        case (k)
            0:             cfg_model.layer_ctrl    = data;
            1, 2, 3, 4, 5: cfg_model.layer_mask[k-1] = data[7:0];
            6, 7, 8, 9:    cfg_model.prio[k-6]     = data;
            default:       cfg_model.gfx_en        = data[3:0];
        endcase
    endtask

    // Sampled at the next edge, then six quiet clocks
    task automatic drive_pixel(input obj_pxl_t obj, input scr_pxl_t s1, input scr_pxl_t s2,
                               input scr_pxl_t s3, input obj_pxl_t st0, input obj_pxl_t st1,
                               input logic checked, input pxl_t expv);
        @(posedge clk);
        pxl_cen   <= 1'b1;
        obj_pxl   <= obj;
        scr1_pxl  <= s1;
        scr2_pxl  <= s2;
        scr3_pxl  <= s3;
        star0_pxl <= st0;
        star1_pxl <= st1;
        exp_q.push_back('{chk: checked, value: expv});
        @(posedge clk);
        pxl_cen <= 1'b0;
        repeat (5) @(posedge clk);
    endtask

    task automatic random_pixel(input logic checked);
        logic [31:0] r0, r1, r2, r3;
        obj_pxl_t    obj, st0, st1;
        scr_pxl_t    s1, s2, s3;
        r0 = next_rand();
        r1 = next_rand();
        r2 = next_rand();
        r3 = next_rand();
        obj = r0[8:0];
        s1  = r0[19:9];
        s2  = r1[10:0];
        s3  = r1[21:11];
        st0 = r2[8:0];
        st1 = r2[17:9];
        // About a quarter of pens forced transparent
        obj[3:0] = obj[3:0] | {4{r3[1:0] == 2'b00}};
        s1[3:0]  = s1[3:0] | {4{r3[3:2] == 2'b00}};
        s2[3:0]  = s2[3:0] | {4{r3[5:4] == 2'b00}};
        s3[3:0]  = s3[3:0] | {4{r3[7:6] == 2'b00}};
        st0[3:0] = st0[3:0] | {4{r3[9:8] == 2'b00}};
        st1[3:0] = st1[3:0] | {4{r3[11:10] == 2'b00}};
        drive_pixel(obj, s1, s2, s3, st0, st1, checked, model_pxl(obj, s1, s2, s3, st0, st1));
    endtask

    // Checked pixels, then two unchecked ones to drain before a config change
    task automatic run_burst(input int n);
        repeat (n) random_pixel(1'b1);
        repeat (2) random_pixel(1'b0);
    endtask

    task automatic random_config(input logic all_on);
        logic [31:0] r;
        r = next_rand();
        write_cfg(ADDR_LAYER_CTRL, {2'b00, r[13:6], (all_on ? 6'h3f : r[5:0])});
        for (int i = 0; i < 5; i++) begin
            r = next_rand();
            write_cfg(ADDR_MASK0 + 2 * i, all_on ? (r[7:0] | 8'h01) : (r[7:0] & r[15:8]));
        end
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            write_cfg(ADDR_PRIO0 + 2 * i, r[15:0]);
        end
        r = next_rand();
        write_cfg(ADDR_GFX_EN, all_on ? 16'h000f : {12'h000, r[3:0] | r[7:4]});
    endtask

    always @(posedge clk) begin
        cen_edge <= !reset && pxl_cen;
    end

    // pxl shows a pixel two enables after it was sampled
    always @(negedge clk) begin : check_outputs
        exp_pxl_t e;
        if (reset) begin
            rgb_due  = 1'b0;
            last_pxl = '0;
        end else begin
            if (rgb_due) begin
                check_value("rgb", pal_copy[rgb_idx], rgb);
            end
            rgb_due  = (pxl != last_pxl);
            rgb_idx  = pxl;
            last_pxl = pxl;
            if (cen_edge) begin
                if (cen_count >= 2) begin
                    if (exp_q.size() == 0) begin
                        error_count++;
                        $display("No expected pixel left for the enable at %0t", $time);
                    end else begin
                        e = exp_q.pop_front();
                        if (e.chk) begin
                            check_value("pxl", {4'h0, e.value}, {4'h0, pxl});
                        end
                    end
                end
                cen_count++;
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [15:0] rd;
        logic [15:0] wd;
        logic        err;
        pxl_t        idx;
        reset     = 1'b1;
        apb_req   = '0;
        pxl_cen   = 1'b0;
        obj_pxl   = '0;
        scr1_pxl  = '0;
        scr2_pxl  = '0;
        scr3_pxl  = '0;
        star0_pxl = '0;
        star1_pxl = '0;
        cfg_model = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Register readback
        for (int k = 0; k < 11; k++) begin
            r = next_rand();
            write_cfg(2 * k, r[15:0]);
        end
        for (int k = 0; k < 11; k++) begin
            apb_xfer(1'b0, 2 * k, 16'h0000, rd, err);
            check_value("prdata", model_reg(k), rd);
            check_value("pslverr", 16'h0000, {15'h0, err});
        end
        // Holes in the map
        for (int k = 0; k < 3; k++) begin
            apb_xfer(1'b1, holes[k], 16'hffff, rd, err);
            check_value("pslverr", 16'h0001, {15'h0, err});
            apb_xfer(1'b0, holes[k], 16'h0000, rd, err);
            check_value("pslverr", 16'h0001, {15'h0, err});
            check_value("prdata", 16'h0000, rd);
        end

        // Palette fill, pattern over the whole index
        for (int i = 0; i < PAL_DEPTH; i++) begin
            wd = {i[3:0], i[11:0]} ^ 16'h9c5a;
            apb_xfer(1'b1, PAL_BASE + 2 * i, wd, rd, err);
            pal_copy[i] = wd;
        end
        for (int i = 0; i < 64; i++) begin
            r   = next_rand();
            idx = r[11:0];
            apb_xfer(1'b0, PAL_BASE + 2 * idx, 16'h0000, rd, err);
            check_value("prdata", pal_copy[idx], rd);
        end

        // All layers live
        repeat (4) begin
            random_config(1'b1);
            run_burst(40);
        end
        // Masks and gfx_en knock layers out
        repeat (6) begin
            random_config(1'b0);
            run_burst(40);
        end

        // Sprite in front of scroll 1, group 2 pen 6
        write_cfg(ADDR_LAYER_CTRL, {2'b00, 2'd3, 2'd2, 2'd0, 2'd1, 6'h3f});
        for (int i = 0; i < 5; i++) begin
            write_cfg(ADDR_MASK0 + 2 * i, 16'h003f);
        end
        write_cfg(ADDR_GFX_EN, 16'h000f);
        write_cfg(ADDR_PRIO2, 16'h0040);
        drive_pixel(9'h139, 11'h4a6, 11'h00f, 11'h00f, 9'h00f, 9'h00f, 1'b1,
                    {LYR_SCR1, 5'h0a, 4'h6});
        repeat (2) random_pixel(1'b0);
        // Pen bit cleared, sprite wins
        write_cfg(ADDR_PRIO2, 16'hffbf);
        drive_pixel(9'h139, 11'h4a6, 11'h00f, 11'h00f, 9'h00f, 9'h00f, 1'b1,
                    {LYR_OBJ, 5'h13, 4'h9});
        repeat (2) random_pixel(1'b0);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
